//--- dv/mouse_uart_bridge_tb.sv
// Mouse bridge testbench
`timescale 1ns/100ps
`include "mouse_defines.svh"

module mouse_uart_bridge_tb;

    import mouse_pkg::*;

    localparam int CLKS = `MOUSE_CLKS_PER_BIT;
    localparam int CLK_NS = 4;
    // single, twenty random, two overflow, one after a stray byte
    localparam int NUM_PACKETS = 24;
    // 120 bit times per packet, margin for reset and idle checks
    localparam int TIMEOUT_NS = NUM_PACKETS * 120 * CLKS * CLK_NS + 2000 * CLK_NS;

    logic      clk;
    logic      rst;
    logic      byte_valid;
    ps2_byte_t byte_data;
    logic      txd;

    // reference model of the tracker registers
    position_t model_x;
    position_t model_y;
    ps2_byte_t model_count;
    ps2_byte_t model_flags;

    mouse_uart_bridge u_dut (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .txd        (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out waiting for serial output");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one-cycle strobe, idle cycle before it
    task automatic send_byte(input ps2_byte_t value);
        @(posedge clk);
        byte_valid <= 1'b1;
        byte_data  <= value;
        @(posedge clk);
        byte_valid <= 1'b0;
    endtask

    // flags give overflow bits 7:6 and buttons 2:0
    task automatic send_packet(input ps2_byte_t flags, input axis_delta_t dx,
                               input axis_delta_t dy);
        ps2_byte_t byte0;
        byte0 = {flags[7:6], dy[8], dx[8], 1'b1, flags[2:0]};
        send_byte(byte0);
        send_byte(dx[7:0]);
        send_byte(dy[7:0]);
        model_count = model_count + 8'd1;
        model_flags = byte0;
        // overflowed axis holds, others wrap freely
        if (!byte0[6]) begin
            model_x = model_x + {{7{dx[8]}}, dx};
        end
        if (!byte0[7]) begin
            model_y = model_y + {{7{dy[8]}}, dy};
        end
    endtask

    // sampled on falling clk, mid bit
    task automatic receive_byte(output ps2_byte_t value);
        @(negedge txd);
        repeat (CLKS / 2) @(negedge clk);
        check_value(32'(txd), 32'd0, "start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk);
            value[i] = txd;
        end
        repeat (CLKS) @(negedge clk);
        check_value(32'(txd), 32'd1, "stop bit");
    endtask

    task automatic expect_frame();
        ps2_byte_t want [8];
        ps2_byte_t got;
        want = '{`MOUSE_START_BYTE_1, `MOUSE_START_BYTE_2, model_count, model_flags,
                 model_x[15:8], model_x[7:0], model_y[15:8], model_y[7:0]};
        for (int i = 0; i < 8; i++) begin
            receive_byte(got);
            check_value(32'(got), 32'(want[i]), $sformatf("frame byte %0d", i));
        end
        // rest of the last stop bit
        repeat (CLKS) @(negedge clk);
    endtask

    task automatic expect_idle(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            check_value(32'(txd), 32'd1, what);
        end
    endtask

    task automatic test_random_packets();
        for (int n = 0; n < 20; n++) begin
            send_packet({5'd0, 3'($urandom)}, 9'($urandom), 9'($urandom));
            expect_frame();
        end
    endtask

    initial begin
        void'($urandom(32'h819fc8e7));
        rst         = 1'b1;
        byte_valid  = 1'b0;
        byte_data   = '0;
        model_x     = '0;
        model_y     = '0;
        model_count = '0;
        model_flags = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        expect_idle(200, "txd idle after reset");
        // small positive move, left button
        send_packet(8'h01, 9'sd5, 9'sd3);
        expect_frame();
        test_random_packets();
        // x overflow, then y overflow
        send_packet(8'h40, 9'sd40, -9'sd7);
        expect_frame();
        send_packet(8'h80, -9'sd12, 9'sd100);
        expect_frame();
        // bit 3 clear, decoder must skip it
        send_byte(8'h07);
        send_packet(8'h02, 9'sd9, -9'sd4);
        expect_frame();
        expect_idle(300, "no frame after stray byte packet");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- dv/report_writer_checker.sv
// Report writer assertions
`timescale 1ns/100ps
`include "mouse_defines.svh"

module report_writer_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      write,
    input logic                      tbr,
    input mouse_pkg::reg_addr_t      addr,
    input mouse_pkg::ps2_byte_t      data_out,
    input mouse_pkg::writer_state_t  state
);

    import mouse_pkg::*;

    // transmitter goes busy after each byte, no second write lands on it
    write_needs_tbr: assert property (@(posedge clk) disable iff (rst) write |=> !tbr)
        else $error("tbr still high the cycle after write");

    // only three registers exist
    addr_in_map: assert property (@(posedge clk) disable iff (rst) addr != 2'd3)
        else $error("addr selects unmapped register 3");

    // first cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !write)
        else $error("write high right after reset");

    // preamble byte
    first_start_byte: assert property (@(posedge clk) disable iff (rst)
        (state == START_BYTE_1) && write |-> data_out == `MOUSE_START_BYTE_1)
        else $error("wrong first start byte");

endmodule

bind report_writer report_writer_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .write    (write),
    .tbr      (tbr),
    .addr     (addr),
    .data_out (data_out),
    .state    (state)
);

//--- mouse_uart_bridge.f
+incdir+source
source/mouse_pkg.sv
source/ps2_packet_decoder.sv
source/position_tracker.sv
source/report_writer.sv
source/uart_tx.sv
source/mouse_uart_bridge.sv
dv/report_writer_checker.sv
dv/mouse_uart_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mouse_uart_bridge_tb \
    -f mouse_uart_bridge.f -o mouse_uart_bridge_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mouse_uart_bridge_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- source/mouse_defines.svh
// Mouse bridge constants
`ifndef MOUSE_DEFINES_SVH
`define MOUSE_DEFINES_SVH

// serial bit time in clock cycles
`define MOUSE_CLKS_PER_BIT 8

// report frame preamble
`define MOUSE_START_BYTE_1 8'hBA
`define MOUSE_START_BYTE_2 8'h11

// register map of the position tracker
// status word: packet count high, flags low
`define MOUSE_ADDR_STATUS 2'd0
// x position
`define MOUSE_ADDR_X 2'd1
// y position
`define MOUSE_ADDR_Y 2'd2

`endif

//--- source/mouse_pkg.sv
// Mouse bridge types
package mouse_pkg;

    // one byte from the mouse or towards the uart
    typedef logic [7:0] ps2_byte_t;

    // sign bit from byte 0 plus a data byte
    typedef logic signed [8:0] axis_delta_t;

    // accumulated coordinate, also one register word
    typedef logic signed [15:0] position_t;

    // register select index
    typedef logic [1:0] reg_addr_t;

    // packet assembly
    typedef enum logic [1:0] {
        BYTE0,
        BYTE1,
        BYTE2
    } decoder_state_t;

    // report frame sequencing
    typedef enum logic [3:0] {
        WAIT,
        START_BYTE_1,
        START_BYTE_2,
        WRITE_STATUS_1,
        WRITE_STATUS_2,
        WRITE_X_1,
        WRITE_X_2,
        WRITE_Y_1,
        WRITE_Y_2
    } writer_state_t;

    // serial transmitter
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

endpackage

//--- source/mouse_uart_bridge.sv
// Mouse to UART bridge top
`timescale 1ns/100ps

module mouse_uart_bridge (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  byte_valid,
    input  mouse_pkg::ps2_byte_t  byte_data,
    output logic                  txd
);

    import mouse_pkg::*;

    // decoder to tracker
    logic        pkt_valid;
    ps2_byte_t   pkt_flags;
    axis_delta_t pkt_dx;
    axis_delta_t pkt_dy;

    // tracker to writer
    reg_addr_t   addr;
    position_t   data_in;
    logic        dav;

    // writer to transmitter
    ps2_byte_t   data_out;
    logic        write;
    logic        tbr;

    ps2_packet_decoder u_decode (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .pkt_valid  (pkt_valid),
        .pkt_flags  (pkt_flags),
        .pkt_dx     (pkt_dx),
        .pkt_dy     (pkt_dy)
    );

    position_tracker u_execute (
        .clk       (clk),
        .rst       (rst),
        .pkt_valid (pkt_valid),
        .pkt_flags (pkt_flags),
        .pkt_dx    (pkt_dx),
        .pkt_dy    (pkt_dy),
        .addr      (addr),
        .data_in   (data_in),
        .dav       (dav)
    );

    report_writer u_result (
        .clk      (clk),
        .rst      (rst),
        .dav      (dav),
        .data_in  (data_in),
        .tbr      (tbr),
        .addr     (addr),
        .data_out (data_out),
        .write    (write)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .write    (write),
        .data_out (data_out),
        .tbr      (tbr),
        .txd      (txd)
    );

endmodule

//--- source/position_tracker.sv
// Pointer position tracker
`timescale 1ns/100ps
`include "mouse_defines.svh"

module position_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pkt_valid,
    input  mouse_pkg::ps2_byte_t    pkt_flags,
    input  mouse_pkg::axis_delta_t  pkt_dx,
    input  mouse_pkg::axis_delta_t  pkt_dy,
    input  mouse_pkg::reg_addr_t    addr,
    output mouse_pkg::position_t    data_in,
    output logic                    dav
);

    import mouse_pkg::*;

    // accumulators, free to wrap
    position_t x_pos;
    position_t y_pos;

    // packets seen, modulo 256
    ps2_byte_t pkt_count;
    // flags byte of the last packet
    ps2_byte_t last_flags;

    position_t status_word;

    // overflow flags in byte 0
    logic x_ovf;
    logic y_ovf;

    assign x_ovf = pkt_flags[6];
    assign y_ovf = pkt_flags[7];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_pos      <= '0;
            y_pos      <= '0;
            pkt_count  <= '0;
            last_flags <= '0;
            dav        <= 1'b0;
        end else begin
            // dav follows pkt_valid by one cycle
            dav <= pkt_valid;
            if (pkt_valid) begin
                // an axis with overflow keeps its old value
                if (!x_ovf) begin
                    x_pos <= x_pos + position_t'(pkt_dx);
                end
                if (!y_ovf) begin
                    y_pos <= y_pos + position_t'(pkt_dy);
                end
                pkt_count  <= pkt_count + 8'd1;
                last_flags <= pkt_flags;
            end
        end
    end

    // count in the high byte, flags in the low byte
    assign status_word = {pkt_count, last_flags};

    // register read, same cycle as addr
    always_comb begin
        case (addr)
            `MOUSE_ADDR_STATUS: data_in = status_word;
            `MOUSE_ADDR_X:      data_in = x_pos;
            `MOUSE_ADDR_Y:      data_in = y_pos;
            // unmapped address
            default:            data_in = '0;
        endcase
    end

endmodule

//--- source/ps2_packet_decoder.sv
// PS/2 movement packet decoder
`timescale 1ns/100ps

module ps2_packet_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    byte_valid,
    input  mouse_pkg::ps2_byte_t    byte_data,
    output logic                    pkt_valid,
    output mouse_pkg::ps2_byte_t    pkt_flags,
    output mouse_pkg::axis_delta_t  pkt_dx,
    output mouse_pkg::axis_delta_t  pkt_dy
);

    import mouse_pkg::*;

    decoder_state_t state;

    // bytes 0 and 1 held until byte 2 shows up
    ps2_byte_t byte0_q;
    ps2_byte_t byte1_q;

    // control path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= BYTE0;
            pkt_valid <= 1'b0;
        end else begin
            // strobe lasts a single cycle
            pkt_valid <= 1'b0;
            if (byte_valid) begin
                case (state)
                    BYTE0: begin
                        // bit 3 is always set in a real first byte
                        if (byte_data[3]) begin
                            state <= BYTE1;
                        end
                    end
                    BYTE1: begin
                        state <= BYTE2;
                    end
                    BYTE2: begin
                        state     <= BYTE0;
                        pkt_valid <= 1'b1;
                    end
                    default: begin
                        state <= BYTE0;
                    end
                endcase
            end
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            case (state)
                BYTE0: begin
                    byte0_q <= byte_data;
                end
                BYTE1: begin
                    byte1_q <= byte_data;
                end
                BYTE2: begin
                    pkt_flags <= byte0_q;
                    // sign bits 4 (x) and 5 (y) sit in byte 0
                    pkt_dx    <= {byte0_q[4], byte1_q};
                    pkt_dy    <= {byte0_q[5], byte_data};
                end
                default: begin
                    byte0_q <= byte0_q;
                end
            endcase
        end
    end

endmodule

//--- source/report_writer.sv
// Report frame writer
`timescale 1ns/100ps
`include "mouse_defines.svh"

module report_writer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dav,
    input  mouse_pkg::position_t  data_in,
    input  logic                  tbr,
    output mouse_pkg::reg_addr_t  addr,
    output mouse_pkg::ps2_byte_t  data_out,
    output logic                  write
);

    import mouse_pkg::*;

    writer_state_t state;
    writer_state_t next_state;
    // where to go once the current byte is written
    writer_state_t step_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        step_state = WAIT;
        addr       = `MOUSE_ADDR_STATUS;
        data_out   = '0;
        // per state: register to read, byte to send, successor
        case (state)
            WAIT: begin
                // dav is only seen here, dropped mid frame
                if (dav) begin
                    next_state = START_BYTE_1;
                end
            end
            START_BYTE_1: begin
                data_out   = `MOUSE_START_BYTE_1;
                step_state = START_BYTE_2;
            end
            START_BYTE_2: begin
                data_out   = `MOUSE_START_BYTE_2;
                step_state = WRITE_STATUS_1;
            end
            WRITE_STATUS_1: begin
                addr       = `MOUSE_ADDR_STATUS;
                data_out   = data_in[15:8];
                step_state = WRITE_STATUS_2;
            end
            WRITE_STATUS_2: begin
                addr       = `MOUSE_ADDR_STATUS;
                data_out   = data_in[7:0];
                step_state = WRITE_X_1;
            end
            WRITE_X_1: begin
                addr       = `MOUSE_ADDR_X;
                data_out   = data_in[15:8];
                step_state = WRITE_X_2;
            end
            WRITE_X_2: begin
                addr       = `MOUSE_ADDR_X;
                data_out   = data_in[7:0];
                step_state = WRITE_Y_1;
            end
            WRITE_Y_1: begin
                addr       = `MOUSE_ADDR_Y;
                data_out   = data_in[15:8];
                step_state = WRITE_Y_2;
            end
            WRITE_Y_2: begin
                addr       = `MOUSE_ADDR_Y;
                data_out   = data_in[7:0];
                // last byte, frame ends
                step_state = WAIT;
            end
            default: begin
                next_state = WAIT;
            end
        endcase

        // one write per state, first cycle the transmitter is free
        write = (state != WAIT) && tbr;
        if (write) begin
            next_state = step_state;
        end
    end

endmodule

//--- source/uart_tx.sv
// UART 8N1 transmitter
`timescale 1ns/100ps
`include "mouse_defines.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `MOUSE_CLKS_PER_BIT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  write,
    input  mouse_pkg::ps2_byte_t  data_out,
    output logic                  tbr,
    output logic                  txd
);

    import mouse_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    tx_state_t  state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0] bit_idx;
    ps2_byte_t  shift_reg;
    logic       bit_done;

    // last cycle of the current bit
    assign bit_done = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // ready only between bytes
    assign tbr = (state == IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (write) begin
                        state <= START;
                        txd   <= 1'b0;
                    end
                end
                START: begin
                    if (bit_done) begin
                        state <= DATA;
                        // lsb goes out first
                        txd   <= shift_reg[0];
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            // next bit before the shift lands
                            txd     <= shift_reg[1];
                        end
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

    // data shifter
    always_ff @(posedge clk) begin
        if ((state == IDLE) && write) begin
            shift_reg <= data_out;
        end else if ((state == DATA) && bit_done) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule
